// File: common/cpu_types_pkg.sv
`default_nettype none

package cpu_types_pkg;

	// datapath and memory word
	localparam int WORD_W = 32;

	typedef logic [WORD_W-1:0] word_t;

	// address fields below the index
	localparam int BYTE_OFF_W = 2;
	localparam int BLOCK_OFF_W = 1;

	// data cache controller states
	typedef enum logic [3:0]
	{
		IDLE,
		// write back a dirty victim before the fetch
		WB0,
		WB1,
		// fetch the two words of the new block
		FETCH0,
		FETCH1,
		// halt walks every set and way
		FLUSH_SCAN,
		FLUSH_WB0,
		FLUSH_WB1,
		FLUSHED
	} dcache_state_t;

endpackage

`default_nettype wire

// File: dcache/dcache_array.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_array #(
	parameter int SETS = 8,
	localparam int IDX_W = $clog2(SETS),
	localparam int TAG_W = cpu_types_pkg::WORD_W - cpu_types_pkg::BYTE_OFF_W
		- cpu_types_pkg::BLOCK_OFF_W - IDX_W
) (
	input  logic                 CLK,
	input  logic                 reset,
	input  cpu_types_pkg::word_t req_addr,
	input  logic                 req_ren,
	input  logic                 req_wen,
	input  cpu_types_pkg::word_t store_data,
	input  logic                 fill_en,
	input  logic                 fill_way,
	input  logic                 fill_word,
	input  cpu_types_pkg::word_t fill_data,
	input  logic                 block_done,
	input  logic                 flush_sel,
	input  logic [IDX_W-1:0]     flush_index,
	input  logic                 flush_way,
	output logic                 hit,
	output cpu_types_pkg::word_t load_data,
	output logic                 victim_way,
	output logic                 victim_dirty,
	output logic [TAG_W-1:0]     victim_tag,
	output cpu_types_pkg::word_t victim_data0,
	output cpu_types_pkg::word_t victim_data1
);

	localparam int IDX_LSB = cpu_types_pkg::BYTE_OFF_W + cpu_types_pkg::BLOCK_OFF_W;

	logic [1:0][SETS-1:0]  valid_q;
	logic [1:0][SETS-1:0]  dirty_q;
	logic [SETS-1:0]       lru_q;
	logic [TAG_W-1:0]      tag_q [2][SETS];
	cpu_types_pkg::word_t  data_q [2][SETS][2];

	logic [IDX_W-1:0]      req_idx;
	logic [TAG_W-1:0]      req_tag;
	logic                  req_word;
	logic [1:0]            way_hit;
	logic                  hit_way;
	logic                  access;
	logic [IDX_W-1:0]      vic_idx;

	assign req_idx = req_addr[IDX_LSB +: IDX_W];
	assign req_tag = req_addr[cpu_types_pkg::WORD_W-1 -: TAG_W];
	assign req_word = req_addr[cpu_types_pkg::BYTE_OFF_W];

	always_comb
	begin
		for (int w = 0; w < 2; w++)
			way_hit[w] = valid_q[w][req_idx] && (tag_q[w][req_idx] == req_tag);
	end

	assign hit = |way_hit;
	assign hit_way = way_hit[1];
	assign access = hit && (req_ren || req_wen);
	assign load_data = data_q[hit_way][req_idx][req_word];

	// lru way on a miss or the scanned block while flushing
	assign vic_idx = flush_sel ? flush_index : req_idx;
	assign victim_way = flush_sel ? flush_way : lru_q[req_idx];
	assign victim_dirty = valid_q[victim_way][vic_idx] && dirty_q[victim_way][vic_idx];
	assign victim_tag = tag_q[victim_way][vic_idx];
	assign victim_data0 = data_q[victim_way][vic_idx][0];
	assign victim_data1 = data_q[victim_way][vic_idx][1];

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			valid_q <= '0;
			dirty_q <= '0;
			lru_q <= '0;
		end
		else
		begin
			if (block_done)
			begin
				valid_q[fill_way][req_idx] <= 1'b1;
				dirty_q[fill_way][req_idx] <= 1'b0;
			end
			if (access)
			begin
				// the way not touched becomes the next victim
				lru_q[req_idx] <= ~hit_way;
				if (req_wen)
					dirty_q[hit_way][req_idx] <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK)
	begin
		if (fill_en)
			data_q[fill_way][req_idx][fill_word] <= fill_data;
		else if (access && req_wen)
			data_q[hit_way][req_idx][req_word] <= store_data;
		if (block_done)
			tag_q[fill_way][req_idx] <= req_tag;
	end

endmodule

`default_nettype wire

// File: dcache/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl #(
	parameter int SETS = 8,
	localparam int IDX_W = $clog2(SETS),
	localparam int TAG_W = cpu_types_pkg::WORD_W - cpu_types_pkg::BYTE_OFF_W
		- cpu_types_pkg::BLOCK_OFF_W - IDX_W
) (
	input  logic                 CLK,
	input  logic                 reset,
	input  logic                 req_ren,
	input  logic                 req_wen,
	input  cpu_types_pkg::word_t req_addr,
	input  logic                 halt,
	input  logic                 hit,
	input  logic                 victim_way,
	input  logic                 victim_dirty,
	input  logic [TAG_W-1:0]     victim_tag,
	input  cpu_types_pkg::word_t victim_data0,
	input  cpu_types_pkg::word_t victim_data1,
	input  logic                 dwait,
	input  cpu_types_pkg::word_t dload,
	output logic                 idle,
	output logic                 mem_ren,
	output logic                 mem_wen,
	output cpu_types_pkg::word_t mem_addr,
	output cpu_types_pkg::word_t mem_store,
	output logic                 fill_en,
	output logic                 fill_way,
	output logic                 fill_word,
	output cpu_types_pkg::word_t fill_data,
	output logic                 block_done,
	output logic                 flush_sel,
	output logic [IDX_W-1:0]     flush_index,
	output logic                 flush_way,
	output logic                 flushed
);

	localparam int IDX_LSB = cpu_types_pkg::BYTE_OFF_W + cpu_types_pkg::BLOCK_OFF_W;

	cpu_types_pkg::dcache_state_t state_q;
	cpu_types_pkg::dcache_state_t state_d;

	// flush position with the set index above the way
	logic [IDX_W:0]    flush_cnt_q;
	logic [IDX_W:0]    flush_cnt_d;

	logic [IDX_W-1:0]  req_idx;
	logic              last_block;
	logic              wb_state;
	logic              flush_wb_state;
	logic              wr_word;

	assign req_idx = req_addr[IDX_LSB +: IDX_W];
	assign last_block = &flush_cnt_q;

	assign wb_state = (state_q == cpu_types_pkg::WB0) || (state_q == cpu_types_pkg::WB1);
	assign flush_wb_state = (state_q == cpu_types_pkg::FLUSH_WB0)
		|| (state_q == cpu_types_pkg::FLUSH_WB1);
	assign wr_word = (state_q == cpu_types_pkg::WB1) || (state_q == cpu_types_pkg::FLUSH_WB1);

	assign idle = (state_q == cpu_types_pkg::IDLE);
	assign flushed = (state_q == cpu_types_pkg::FLUSHED);
	assign flush_sel = (state_q == cpu_types_pkg::FLUSH_SCAN) || flush_wb_state;
	assign flush_index = flush_cnt_q[IDX_W:1];
	assign flush_way = flush_cnt_q[0];

	assign mem_ren = (state_q == cpu_types_pkg::FETCH0) || (state_q == cpu_types_pkg::FETCH1);
	assign mem_wen = wb_state || flush_wb_state;
	assign mem_store = wr_word ? victim_data1 : victim_data0;

	// fetched words land in the victim way as they arrive
	assign fill_way = victim_way;
	assign fill_word = (state_q == cpu_types_pkg::FETCH1);
	assign fill_data = dload;
	assign fill_en = mem_ren && !dwait;
	assign block_done = (state_q == cpu_types_pkg::FETCH1) && !dwait;

	always_comb
	begin
		if (flush_wb_state)
			mem_addr = {victim_tag, flush_index, wr_word, {cpu_types_pkg::BYTE_OFF_W{1'b0}}};
		else if (wb_state)
			mem_addr = {victim_tag, req_idx, wr_word, {cpu_types_pkg::BYTE_OFF_W{1'b0}}};
		else
			mem_addr = {req_addr[cpu_types_pkg::WORD_W-1:IDX_LSB], fill_word,
				{cpu_types_pkg::BYTE_OFF_W{1'b0}}};
	end

	always_comb
	begin
		state_d = state_q;
		flush_cnt_d = flush_cnt_q;
		case (state_q)
			cpu_types_pkg::IDLE:
			begin
				flush_cnt_d = '0;
				if (halt)
					state_d = cpu_types_pkg::FLUSH_SCAN;
				else if ((req_ren || req_wen) && !hit)
					state_d = victim_dirty ? cpu_types_pkg::WB0 : cpu_types_pkg::FETCH0;
			end
			cpu_types_pkg::WB0:
				if (!dwait)
					state_d = cpu_types_pkg::WB1;
			cpu_types_pkg::WB1:
				if (!dwait)
					state_d = cpu_types_pkg::FETCH0;
			cpu_types_pkg::FETCH0:
				if (!dwait)
					state_d = cpu_types_pkg::FETCH1;
			cpu_types_pkg::FETCH1:
				// the request then completes as a hit
				if (!dwait)
					state_d = cpu_types_pkg::IDLE;
			cpu_types_pkg::FLUSH_SCAN:
			begin
				if (victim_dirty)
					state_d = cpu_types_pkg::FLUSH_WB0;
				else if (last_block)
					state_d = cpu_types_pkg::FLUSHED;
				else
					flush_cnt_d = flush_cnt_q + 1'b1;
			end
			cpu_types_pkg::FLUSH_WB0:
				if (!dwait)
					state_d = cpu_types_pkg::FLUSH_WB1;
			cpu_types_pkg::FLUSH_WB1:
			begin
				if (!dwait)
				begin
					if (last_block)
						state_d = cpu_types_pkg::FLUSHED;
					else
					begin
						state_d = cpu_types_pkg::FLUSH_SCAN;
						flush_cnt_d = flush_cnt_q + 1'b1;
					end
				end
			end
			cpu_types_pkg::FLUSHED:
				// held until reset
				state_d = cpu_types_pkg::FLUSHED;
			default:
				state_d = cpu_types_pkg::IDLE;
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			state_q <= cpu_types_pkg::IDLE;
			flush_cnt_q <= '0;
		end
		else
		begin
			state_q <= state_d;
			flush_cnt_q <= flush_cnt_d;
		end
	end

endmodule

`default_nettype wire

// File: hdl/dcache.sv
`timescale 1ns/1ps
`default_nettype none

module dcache #(
	parameter int SETS = 8
) (
	input  logic                 CLK,
	input  logic                 reset,
	input  logic                 dmem_ren,
	input  logic                 dmem_wen,
	input  cpu_types_pkg::word_t dmem_addr,
	input  cpu_types_pkg::word_t dmem_store,
	input  logic                 halt,
	input  logic                 dwait,
	input  cpu_types_pkg::word_t dload,
	output logic                 dhit,
	output cpu_types_pkg::word_t dmem_load,
	output logic                 flushed,
	output logic                 mem_ren,
	output logic                 mem_wen,
	output cpu_types_pkg::word_t mem_addr,
	output cpu_types_pkg::word_t mem_store
);

	localparam int IDX_W = $clog2(SETS);
	localparam int TAG_W = cpu_types_pkg::WORD_W - cpu_types_pkg::BYTE_OFF_W
		- cpu_types_pkg::BLOCK_OFF_W - IDX_W;

	logic                  hit;
	logic                  ctrl_idle;
	logic                  arr_ren;
	logic                  arr_wen;
	logic                  victim_way;
	logic                  victim_dirty;
	logic [TAG_W-1:0]      victim_tag;
	cpu_types_pkg::word_t  victim_data0;
	cpu_types_pkg::word_t  victim_data1;
	logic                  fill_en;
	logic                  fill_way;
	logic                  fill_word;
	cpu_types_pkg::word_t  fill_data;
	logic                  block_done;
	logic                  flush_sel;
	logic [IDX_W-1:0]      flush_index;
	logic                  flush_way;

	// datapath access only counts while the controller is idle
	assign arr_ren = dmem_ren && ctrl_idle;
	assign arr_wen = dmem_wen && ctrl_idle;
	assign dhit = hit && (arr_ren || arr_wen);

	dcache_array #(
		.SETS(SETS)
	) u_array (
		.CLK(CLK),
		.reset(reset),
		.req_addr(dmem_addr),
		.req_ren(arr_ren),
		.req_wen(arr_wen),
		.store_data(dmem_store),
		.fill_en(fill_en),
		.fill_way(fill_way),
		.fill_word(fill_word),
		.fill_data(fill_data),
		.block_done(block_done),
		.flush_sel(flush_sel),
		.flush_index(flush_index),
		.flush_way(flush_way),
		.hit(hit),
		.load_data(dmem_load),
		.victim_way(victim_way),
		.victim_dirty(victim_dirty),
		.victim_tag(victim_tag),
		.victim_data0(victim_data0),
		.victim_data1(victim_data1)
	);

	dcache_ctrl #(
		.SETS(SETS)
	) u_ctrl (
		.CLK(CLK),
		.reset(reset),
		.req_ren(dmem_ren),
		.req_wen(dmem_wen),
		.req_addr(dmem_addr),
		.halt(halt),
		.hit(hit),
		.victim_way(victim_way),
		.victim_dirty(victim_dirty),
		.victim_tag(victim_tag),
		.victim_data0(victim_data0),
		.victim_data1(victim_data1),
		.dwait(dwait),
		.dload(dload),
		.idle(ctrl_idle),
		.mem_ren(mem_ren),
		.mem_wen(mem_wen),
		.mem_addr(mem_addr),
		.mem_store(mem_store),
		.fill_en(fill_en),
		.fill_way(fill_way),
		.fill_word(fill_word),
		.fill_data(fill_data),
		.block_done(block_done),
		.flush_sel(flush_sel),
		.flush_index(flush_index),
		.flush_way(flush_way),
		.flushed(flushed)
	);

endmodule

`default_nettype wire

// File: verif/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

	localparam int SETS = 8;
	localparam int ACCESS_TIMEOUT = 200;
	localparam int FLUSH_TIMEOUT = 4000;
	localparam cpu_types_pkg::word_t FILL_PATTERN = 32'h5a3c_96e1;

	logic                 CLK;
	logic                 reset;
	logic                 dmem_ren;
	logic                 dmem_wen;
	cpu_types_pkg::word_t dmem_addr;
	cpu_types_pkg::word_t dmem_store;
	logic                 halt;
	logic                 dwait;
	cpu_types_pkg::word_t dload;
	logic                 dhit;
	cpu_types_pkg::word_t dmem_load;
	logic                 flushed;
	logic                 mem_ren;
	logic                 mem_wen;
	cpu_types_pkg::word_t mem_addr;
	cpu_types_pkg::word_t mem_store;

	// main memory behind the cache and the data the datapath expects to see
	cpu_types_pkg::word_t backing [cpu_types_pkg::word_t];
	cpu_types_pkg::word_t golden [cpu_types_pkg::word_t];

	integer seed = 78731;

	dcache #(
		.SETS(SETS)
	) u_dut (
		.CLK(CLK),
		.reset(reset),
		.dmem_ren(dmem_ren),
		.dmem_wen(dmem_wen),
		.dmem_addr(dmem_addr),
		.dmem_store(dmem_store),
		.halt(halt),
		.dwait(dwait),
		.dload(dload),
		.dhit(dhit),
		.dmem_load(dmem_load),
		.flushed(flushed),
		.mem_ren(mem_ren),
		.mem_wen(mem_wen),
		.mem_addr(mem_addr),
		.mem_store(mem_store)
	);

	// unwritten words read as word address xor a pattern
	function automatic cpu_types_pkg::word_t fill_value(input cpu_types_pkg::word_t addr);
		return (addr >> 2) ^ FILL_PATTERN;
	endfunction

	function automatic cpu_types_pkg::word_t backing_read(input cpu_types_pkg::word_t addr);
		cpu_types_pkg::word_t value;
		if (backing.exists(addr))
			value = backing[addr];
		else
			value = fill_value(addr);
		return value;
	endfunction

	function automatic cpu_types_pkg::word_t expected_load(input cpu_types_pkg::word_t addr);
		cpu_types_pkg::word_t value;
		if (golden.exists(addr))
			value = golden[addr];
		else
			value = fill_value(addr);
		return value;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_word(input string name, input cpu_types_pkg::word_t got,
		input cpu_types_pkg::word_t exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
	endtask

	// one datapath request held until dhit
	task automatic datapath_access(input logic wr, input cpu_types_pkg::word_t addr,
		input cpu_types_pkg::word_t data, output logic saw_ren, output logic saw_wen,
		output int latency);
		logic done;
		done = 1'b0;
		saw_ren = 1'b0;
		saw_wen = 1'b0;
		latency = 0;
		@(negedge CLK);
		dmem_ren = !wr;
		dmem_wen = wr;
		dmem_addr = addr;
		dmem_store = data;
		while (!done)
		begin
			@(posedge CLK);
			saw_ren = saw_ren | mem_ren;
			saw_wen = saw_wen | mem_wen;
			if (dhit)
				done = 1'b1;
			else
			begin
				latency++;
				if (latency > ACCESS_TIMEOUT)
					abort_run($sformatf("timeout: access to %h never completed", addr));
			end
		end
		@(negedge CLK);
		dmem_ren = 1'b0;
		dmem_wen = 1'b0;
	endtask

	initial
	begin
		CLK = 1'b0;
		forever
			#2 CLK = ~CLK;
	end

	// memory model with a random wait of 0 to 3 cycles per word
	initial
	begin
		int   wait_left;
		logic in_word;
		wait_left = 0;
		in_word = 1'b0;
		dwait = 1'b1;
		dload = '0;
		forever
		begin
			@(negedge CLK);
			if (reset || !(mem_ren || mem_wen))
			begin
				dwait = 1'b1;
				in_word = 1'b0;
			end
			else
			begin
				if (!in_word)
				begin
					wait_left = $random(seed) & 3;
					in_word = 1'b1;
				end
				if (wait_left > 0)
				begin
					dwait = 1'b1;
					wait_left--;
				end
				else
				begin
					// word completes at the next rising edge
					dwait = 1'b0;
					in_word = 1'b0;
					if (mem_wen)
						backing[mem_addr] = mem_store;
					else
						dload = backing_read(mem_addr);
				end
			end
		end
	end

	// compare loads and record stores at the edge where the access completes
	always @(posedge CLK)
	begin
		if (!reset && dhit)
		begin
			if (dmem_ren)
				check_word("dmem_load", dmem_load, expected_load(dmem_addr));
			else if (dmem_wen)
				golden[dmem_addr] = dmem_store;
		end
	end

	initial
	begin
		logic                 saw_ren;
		logic                 saw_wen;
		logic                 wr;
		int                   latency;
		int                   timer;
		cpu_types_pkg::word_t addr;
		cpu_types_pkg::word_t data;
		reset = 1'b1;
		dmem_ren = 1'b0;
		dmem_wen = 1'b0;
		dmem_addr = '0;
		dmem_store = '0;
		halt = 1'b0;
		repeat (10) @(posedge CLK);
		@(negedge CLK);
		reset = 1'b0;
		check_bit("flushed after reset", flushed, 1'b0);
		check_bit("mem_ren after reset", mem_ren, 1'b0);
		check_bit("mem_wen after reset", mem_wen, 1'b0);

		// cold miss then the neighbour word hits at once
		datapath_access(1'b0, 32'h0000_0100, '0, saw_ren, saw_wen, latency);
		check_bit("mem_ren during load miss", saw_ren, 1'b1);
		datapath_access(1'b0, 32'h0000_0104, '0, saw_ren, saw_wen, latency);
		check_bit("dhit in request cycle", latency == 0, 1'b1);
		check_bit("mem_ren on hit", saw_ren, 1'b0);
		check_bit("mem_wen on hit", saw_wen, 1'b0);

		// store hit leaves the other word alone
		datapath_access(1'b1, 32'h0000_0104, 32'hdead_beef, saw_ren, saw_wen, latency);
		check_bit("dhit on store hit", latency == 0, 1'b1);
		datapath_access(1'b0, 32'h0000_0104, '0, saw_ren, saw_wen, latency);
		datapath_access(1'b0, 32'h0000_0100, '0, saw_ren, saw_wen, latency);

		// three tags in set 0 push the dirty block out
		datapath_access(1'b0, 32'h0000_0140, '0, saw_ren, saw_wen, latency);
		datapath_access(1'b0, 32'h0000_0180, '0, saw_ren, saw_wen, latency);
		check_bit("mem_wen during dirty eviction", saw_wen, 1'b1);
		check_word("backing word 00000104", backing_read(32'h0000_0104), 32'hdead_beef);
		datapath_access(1'b0, 32'h0000_0104, '0, saw_ren, saw_wen, latency);

		for (int i = 0; i < 200; i++)
		begin
			wr = ($random(seed) & 1) != 0;
			addr = $random(seed) & 32'h0000_01fc;
			data = $random(seed);
			datapath_access(wr, addr, data, saw_ren, saw_wen, latency);
		end

		@(negedge CLK);
		halt = 1'b1;
		timer = 0;
		while (!flushed)
		begin
			@(negedge CLK);
			timer++;
			if (timer > FLUSH_TIMEOUT)
				abort_run("timeout: flushed did not rise after halt");
		end
		repeat (20)
		begin
			@(negedge CLK);
			check_bit("flushed", flushed, 1'b1);
		end
		foreach (golden[a])
			check_word($sformatf("backing word %h", a), backing_read(a), golden[a]);

		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: dcache.f
common/cpu_types_pkg.sv
dcache/dcache_array.sv
dcache/dcache_ctrl.sv
hdl/dcache.sv
verif/dcache_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
TOP       ?= dcache_tb
FILELIST  ?= dcache.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := *** FAILED ***
PASS_MSG  := *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
